//--- Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - common
    files:
      - common/rv_pkg.sv
      - common/dmem_if.sv
      - hw/pipe_reg.sv
      - core/regfile.sv
      - core/decode.sv
      - core/execute.sv
      - core/mem_access.sv
      - hw/rv_core.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/rv_core_tb.sv

//--- common/dmem_if.sv
`timescale 1ns/1ns
`default_nettype none

interface dmem_if ();
    import rv_pkg::*;

    logic  req;
    logic  write;
    word_t addr;
    word_t wdata;
    word_t rdata;
    logic  ack;  // Completes the access in the same cycle

    modport master (output req, write, addr, wdata, input rdata, ack);
    modport slave (input req, write, addr, wdata, output rdata, ack);

endinterface

`default_nettype wire

//--- common/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RESET_PC 32'h0001_0000

// RV32I major opcodes
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011

`define NUM_REGS 32

`endif

//--- common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // LUI
    } alu_op_e;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        word_t     pc;
        word_t     op_a;
        word_t     op_b;
        word_t     store_data;
        reg_addr_t rd;
        alu_op_e   alu_op;
        logic      is_load;
        logic      is_store;
        logic      writes_rd;
    } id_ex_t;

    typedef struct packed {
        word_t     result;  // Also the address of a load or store
        word_t     store_data;
        reg_addr_t rd;
        logic      is_load;
        logic      is_store;
        logic      writes_rd;
    } ex_mem_t;

    typedef struct packed {
        word_t     result;
        reg_addr_t rd;
        logic      writes_rd;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- core/decode.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module decode (
    input  rv_pkg::word_t     instr,
    input  rv_pkg::word_t     pc,
    input  logic              valid,
    output rv_pkg::reg_addr_t rs1,
    output rv_pkg::reg_addr_t rs2,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    input  rv_pkg::reg_addr_t ex_rd,
    input  logic              ex_writes,
    input  rv_pkg::reg_addr_t mem_rd,
    input  logic              mem_writes,
    output logic              hazard_stall,
    output rv_pkg::id_ex_t    payload
);
    import rv_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    word_t   imm_i, imm_s, imm_u;
    logic    is_op, is_op_imm, is_lui, is_load, is_store;
    logic    use_rs1, use_rs2;
    alu_op_e alu_op;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {instr[31:12], 12'b0};

    assign is_op     = opcode == `OPC_OP;
    assign is_op_imm = opcode == `OPC_OP_IMM;
    assign is_lui    = opcode == `OPC_LUI;
    assign is_load   = opcode == `OPC_LOAD && funct3 == 3'b010;   // LW only
    assign is_store  = opcode == `OPC_STORE && funct3 == 3'b010;  // SW only

    assign use_rs1 = is_op || is_op_imm || is_load || is_store;
    assign use_rs2 = is_op || is_store;

    always_comb begin
        alu_op = ALU_ADD;  // Loads and stores add base and offset
        if (is_lui) begin
            alu_op = ALU_PASS_B;
        end else if (is_op || is_op_imm) begin
            case (funct3)
                3'b000:  alu_op = (is_op && funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    // Source waits while an older writer sits in execute or memory
    function automatic logic src_hit(reg_addr_t src, logic used, reg_addr_t dst, logic writes);
        return used && src != '0 && writes && src == dst;
    endfunction

    assign hazard_stall = valid && (
        src_hit(rs1, use_rs1, ex_rd, ex_writes) || src_hit(rs1, use_rs1, mem_rd, mem_writes) ||
        src_hit(rs2, use_rs2, ex_rd, ex_writes) || src_hit(rs2, use_rs2, mem_rd, mem_writes));

    always_comb begin
        payload.pc         = pc;
        payload.op_a       = rs1_data;
        payload.op_b       = is_op ? rs2_data : is_store ? imm_s : is_lui ? imm_u : imm_i;
        payload.store_data = rs2_data;
        payload.rd         = instr[11:7];
        payload.alu_op     = alu_op;
        payload.is_load    = is_load;
        payload.is_store   = is_store;
        payload.writes_rd  = is_op || is_op_imm || is_lui || is_load;  // Others are no-ops
    end

endmodule

`default_nettype wire

//--- core/execute.sv
`timescale 1ns/1ns
`default_nettype none

module execute (
    input  rv_pkg::id_ex_t  in_data,
    output rv_pkg::ex_mem_t out_data
);
    import rv_pkg::*;

    word_t      a, b;
    logic [4:0] shamt;
    word_t      alu_out;

    assign a     = in_data.op_a;
    assign b     = in_data.op_b;
    assign shamt = b[4:0];

    // For loads and stores decode selects ALU_ADD, giving base plus offset
    always_comb begin
        case (in_data.alu_op)
            ALU_ADD:    alu_out = a + b;
            ALU_SUB:    alu_out = a - b;
            ALU_SLL:    alu_out = a << shamt;
            ALU_SLT:    alu_out = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:   alu_out = {31'b0, a < b};
            ALU_XOR:    alu_out = a ^ b;
            ALU_SRL:    alu_out = a >> shamt;
            ALU_SRA:    alu_out = $signed(a) >>> shamt;
            ALU_OR:     alu_out = a | b;
            ALU_AND:    alu_out = a & b;
            ALU_PASS_B: alu_out = b;
            default:    alu_out = '0;
        endcase
    end

    always_comb begin
        out_data.result     = alu_out;
        out_data.store_data = in_data.store_data;
        out_data.rd         = in_data.rd;
        out_data.is_load    = in_data.is_load;
        out_data.is_store   = in_data.is_store;
        out_data.writes_rd  = in_data.writes_rd;
    end

endmodule

`default_nettype wire

//--- core/mem_access.sv
`timescale 1ns/1ns
`default_nettype none

module mem_access (
    input  logic            clk,
    input  logic            rst,
    input  logic            valid,
    input  rv_pkg::ex_mem_t in_data,
    dmem_if.master          dmem,
    output logic            mem_stall,
    output rv_pkg::mem_wb_t out_data
);
    import rv_pkg::*;

    logic access;

    assign access = valid && (in_data.is_load || in_data.is_store);

    // The EX/MEM register holds while stalled, keeping the request stable
    assign dmem.req   = access;
    assign dmem.write = valid && in_data.is_store;
    assign dmem.addr  = in_data.result;
    assign dmem.wdata = in_data.store_data;

    assign mem_stall = access && !dmem.ack;

    // Load data is taken in the ack cycle, when MEM/WB loads
    always_comb begin
        out_data.result    = in_data.is_load ? dmem.rdata : in_data.result;
        out_data.rd        = in_data.rd;
        out_data.writes_rd = in_data.writes_rd;
    end

    req_stable: assert property (@(posedge clk) disable iff (rst)
        dmem.req && !dmem.ack |=> dmem.req && $stable(dmem.addr) &&
            $stable(dmem.write) && $stable(dmem.wdata));

endmodule

`default_nettype wire

//--- core/regfile.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module regfile (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    input  logic              we,
    input  rv_pkg::reg_addr_t rd,
    input  rv_pkg::word_t     wd
);
    import rv_pkg::*;

    word_t regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin  // x0 never written
            regs[rd] <= wd;
        end
    end

    // Write bypass
    assign rs1_data = (rs1 == '0) ? '0 : (we && rd == rs1) ? wd : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : (we && rd == rs2) ? wd : regs[rs2];

endmodule

`default_nettype wire

//--- hw/pipe_reg.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     bubble,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // Stall wins over bubble so a held stage is never lost
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= in_valid && !bubble;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            out_data <= in_data;
        end
    end

    valid_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(out_valid));

endmodule

`default_nettype wire

//--- hw/rv_core.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module rv_core (
    input  logic          clk,
    input  logic          rst,

    output rv_pkg::word_t iaddr,
    input  rv_pkg::word_t idata,
    input  logic          iack,

    output logic          dmem_req,
    output logic          dmem_write,
    output rv_pkg::word_t dmem_addr,
    output rv_pkg::word_t dmem_wdata,
    input  rv_pkg::word_t dmem_rdata,
    input  logic          dmem_ack
);
    import rv_pkg::*;

    word_t     pc;
    logic      hazard_stall, mem_stall, front_stall;
    reg_addr_t rs1, rs2;
    word_t     rs1_data, rs2_data;

    if_id_t  if_d, if_q;
    id_ex_t  id_d, id_q;
    ex_mem_t ex_d, ex_q;
    mem_wb_t mem_d, mem_q;
    logic    if_valid, id_valid, ex_valid, mem_valid;

    dmem_if dmem ();

    assign front_stall = mem_stall || hazard_stall;

    // PC holds and iack is ignored while the front end is stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (!front_stall && iack) begin
            pc <= pc + 32'd4;
        end
    end

    assign iaddr = pc;
    assign if_d  = '{pc: pc, instr: idata};

    pipe_reg #(.payload_t(if_id_t)) if_id_reg (
        .clk(clk), .rst(rst), .stall(front_stall), .bubble(1'b0),
        .in_valid(iack), .in_data(if_d), .out_valid(if_valid), .out_data(if_q)
    );

    decode decode_inst (
        .instr(if_q.instr), .pc(if_q.pc), .valid(if_valid),
        .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .ex_rd(id_q.rd), .ex_writes(id_valid && id_q.writes_rd),
        .mem_rd(ex_q.rd), .mem_writes(ex_valid && ex_q.writes_rd),
        .hazard_stall(hazard_stall), .payload(id_d)
    );

    pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk(clk), .rst(rst), .stall(mem_stall), .bubble(hazard_stall),
        .in_valid(if_valid), .in_data(id_d), .out_valid(id_valid), .out_data(id_q)
    );

    execute execute_inst (.in_data(id_q), .out_data(ex_d));

    pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
        .clk(clk), .rst(rst), .stall(mem_stall), .bubble(1'b0),
        .in_valid(id_valid), .in_data(ex_d), .out_valid(ex_valid), .out_data(ex_q)
    );

    mem_access mem_access_inst (
        .clk(clk), .rst(rst), .valid(ex_valid), .in_data(ex_q),
        .dmem(dmem), .mem_stall(mem_stall), .out_data(mem_d)
    );

    assign dmem_req   = dmem.req;
    assign dmem_write = dmem.write;
    assign dmem_addr  = dmem.addr;
    assign dmem_wdata = dmem.wdata;
    assign dmem.rdata = dmem_rdata;
    assign dmem.ack   = dmem_ack;

    pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
        .clk(clk), .rst(rst), .stall(mem_stall), .bubble(1'b0),
        .in_valid(ex_valid), .in_data(mem_d), .out_valid(mem_valid), .out_data(mem_q)
    );

    // Writeback
    regfile regfile_inst (
        .clk(clk), .rst(rst),
        .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .we(mem_valid && mem_q.writes_rd), .rd(mem_q.rd), .wd(mem_q.result)
    );

endmodule

`default_nettype wire

//--- rv_core.f
+incdir+common
common/rv_pkg.sv
common/dmem_if.sv
hw/pipe_reg.sv
core/regfile.sv
core/decode.sv
core/execute.sv
core/mem_access.sv
hw/rv_core.sv
tests/rv_core_tb.sv

//--- tests/rv_core_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module rv_core_tb;
    import rv_pkg::*;

    localparam int    CLK_PERIOD = 20;
    localparam int    BODY_LEN   = 200;
    localparam int    TIMEOUT_NS = (BODY_LEN + 8) * 8 * CLK_PERIOD + 100 * CLK_PERIOD;
    localparam word_t NOP        = 32'h0000_0013;  // ADDI x0, x0, 0

    logic  clk = 1'b0;
    logic  rst;
    word_t iaddr;
    word_t idata;
    logic  iack;
    logic  dmem_req;
    logic  dmem_write;
    word_t dmem_addr;
    word_t dmem_wdata;
    word_t dmem_rdata;
    logic  dmem_ack;

    word_t prog [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t dmem [64];
    word_t model_mem [64];
    word_t model_regs [`NUM_REGS];

    word_t last_iaddr;
    logic  held = 1'b0;  // Request seen last cycle without ack
    logic  held_write;
    word_t held_addr;
    word_t held_wdata;

    rv_core rv_core_inst (
        .clk(clk), .rst(rst),
        .iaddr(iaddr), .idata(idata), .iack(iack),
        .dmem_req(dmem_req), .dmem_write(dmem_write), .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata), .dmem_ack(dmem_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_stop(string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("[FAIL] %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(string name, word_t got, word_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("[FAIL] %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            fail_stop($sformatf("[FAIL] %s = %h, expected %h", name, got, exp));
        end
    endtask

    function automatic word_t make_lw(reg_addr_t rd, logic [5:0] widx);
        logic [11:0] off;
        off = {4'b0, widx, 2'b0};
        return {off, 5'd0, 3'b010, rd, `OPC_LOAD};
    endfunction

    function automatic word_t make_sw(reg_addr_t rs2, logic [5:0] widx);
        logic [11:0] off;
        off = {4'b0, widx, 2'b0};
        return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], `OPC_STORE};
    endfunction

    // Only x0..x7 so that dependencies are frequent
    task automatic gen_program();
        word_t       rnd;
        funct3_t     f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        reg_addr_t   rd, rs1, rs2;
        while (prog.size() < BODY_LEN) begin
            rnd = $urandom;
            f3  = rnd[14:12];
            rd  = {2'b0, rnd[2:0]};
            rs1 = {2'b0, rnd[5:3]};
            rs2 = {2'b0, rnd[8:6]};
            imm = rnd[31:20];
            case ($urandom % 9)
                0, 1, 2: begin
                    f7 = (rnd[9] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
                    prog.push_back({f7, rs2, rs1, f3, rd, `OPC_OP});
                end
                3, 4: begin
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        imm = {(rnd[9] && f3 == 3'd5) ? 7'h20 : 7'h00, rnd[24:20]};
                    end
                    prog.push_back({imm, rs1, f3, rd, `OPC_OP_IMM});
                end
                5: prog.push_back({rnd[31:12], rd, `OPC_LUI});
                6: prog.push_back(make_lw(rd, rnd[21:16]));
                7: prog.push_back(make_sw(rs2, rnd[21:16]));
                default: begin  // Load then dependent store
                    prog.push_back(make_lw(rd, rnd[21:16]));
                    prog.push_back(make_sw(rd, rnd[27:22]));
                end
            endcase
        end
        for (int r = 0; r < 8; r++) begin
            prog.push_back(make_sw(reg_addr_t'(r), 6'(56 + r)));
        end
    endtask

    function automatic word_t alu_ref(funct3_t f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // In-order ISA model that fills the expected store stream
    task automatic model_exec(word_t instr);
        word_t   a, b, imm_i, imm_s, addr, res;
        funct3_t f3;
        logic    wr;
        f3    = instr[14:12];
        a     = model_regs[instr[19:15]];
        b     = model_regs[instr[24:20]];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        res   = '0;
        wr    = 1'b1;
        case (instr[6:0])
            `OPC_OP:     res = alu_ref(f3, instr[30], a, b);
            `OPC_OP_IMM: res = alu_ref(f3, instr[30] && f3 == 3'd5, a, imm_i);
            `OPC_LUI:    res = {instr[31:12], 12'b0};
            `OPC_LOAD: begin
                addr = a + imm_i;
                res  = model_mem[addr[7:2]];
            end
            `OPC_STORE: begin
                addr = a + imm_s;
                wr   = 1'b0;
                exp_addr.push_back(addr);
                exp_data.push_back(b);
                model_mem[addr[7:2]] = b;
            end
            default: wr = 1'b0;
        endcase
        if (wr && instr[11:7] != 5'd0) begin
            model_regs[instr[11:7]] = res;
        end
    endtask

    function automatic word_t fetch_word(word_t addr);
        word_t idx;
        idx = (addr - `RESET_PC) >> 2;
        if (addr >= `RESET_PC && idx < prog.size()) begin
            return prog[idx];
        end
        return NOP;  // Padding behind the program
    endfunction

    task automatic commit_store();
        if (exp_addr.size() == 0) begin
            fail_stop("Store issued after the last expected store");
        end
        check_addr("dmem_addr", dmem_addr, exp_addr.pop_front());
        check_word("dmem_wdata", dmem_wdata, exp_data.pop_front());
        dmem[dmem_addr[7:2]] = dmem_wdata;
    endtask

    // Runs on the falling edge, decides what the next rising edge sees
    task automatic drive_cycle();
        if (iaddr !== last_iaddr) begin
            check_addr("iaddr", iaddr, last_iaddr + 32'd4);
            last_iaddr = iaddr;
        end
        iack  = ($urandom % 4) != 0;
        idata = iack ? fetch_word(iaddr) : $urandom;
        if (held) begin
            check_bit("dmem_req", dmem_req, 1'b1);
            check_bit("dmem_write", dmem_write, held_write);
            check_addr("dmem_addr", dmem_addr, held_addr);
            check_word("dmem_wdata", dmem_wdata, held_wdata);
        end
        dmem_ack   = dmem_req && ($urandom % 3) != 0;
        dmem_rdata = dmem_req ? dmem[dmem_addr[7:2]] : $urandom;
        if (dmem_ack && dmem_write) begin
            commit_store();
        end
        held       = dmem_req && !dmem_ack;
        held_write = dmem_write;
        held_addr  = dmem_addr;
        held_wdata = dmem_wdata;
    endtask

    initial begin
        #(TIMEOUT_NS);
        fail_stop("Watchdog expired with stores still outstanding");
    end

    initial begin
        void'($urandom(32'hfdda_6458));
        rst        = 1'b1;
        iack       = 1'b0;
        idata      = NOP;
        dmem_ack   = 1'b0;
        dmem_rdata = '0;

        gen_program();
        for (int i = 0; i < 64; i++) begin
            dmem[i]      = $urandom;
            model_mem[i] = dmem[i];
        end
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        foreach (prog[i]) begin
            model_exec(prog[i]);
        end

        repeat (2) @(negedge clk);
        check_addr("iaddr", iaddr, `RESET_PC);
        check_bit("dmem_req", dmem_req, 1'b0);
        check_bit("dmem_write", dmem_write, 1'b0);
        rst        = 1'b0;
        last_iaddr = iaddr;

        while (exp_addr.size() != 0) begin
            drive_cycle();
            @(negedge clk);
        end
        repeat (20) begin  // Catch duplicated stores
            drive_cycle();
            @(negedge clk);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
